/* grid_defs.svh */
`ifndef GRID_DEFS_SVH
`define GRID_DEFS_SVH

// grid geometry
`define GRID_COLS 16
`define GRID_ROWS 8

// bank word and transfer width
`define CHUNK_WIDTH 8
`define CHUNKS_PER_ROW (`GRID_COLS / `CHUNK_WIDTH)
`define BANK_DEPTH (`GRID_ROWS * `CHUNKS_PER_ROW)
`define BANK_ADDR_WIDTH $clog2(`BANK_DEPTH)

// a live cell with fewer live neighbours than this is cleared
`define PRUNE_MIN 4
`define COUNT_WIDTH 16

// apb side
`define APB_ADDR_WIDTH 12
`define APB_DATA_WIDTH 32
`define GRID_WINDOW_BASE 'h40

`endif

/* grid_pkg.sv */
`default_nettype none

package grid_pkg;

    // one pruning pass
    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_LOAD,
        ENG_SWEEP,
        ENG_STORE,
        ENG_DONE
    } engine_state_t;

    // passes repeated until stable
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_WAIT,
        SEQ_FINISHED
    } seq_state_t;

endpackage

`default_nettype wire

/* host_pkg.sv */
`default_nettype none

package host_pkg;

    typedef enum logic [2:0] {
        REG_CTRL,
        REG_STATUS,
        REG_REMOVED,
        REG_PASSES,
        REG_GRID,
        REG_NONE
    } reg_sel_t;

    // register byte offsets
    localparam int OFFSET_CTRL    = 'h00;
    localparam int OFFSET_STATUS  = 'h04;
    localparam int OFFSET_REMOVED = 'h08;
    localparam int OFFSET_PASSES  = 'h0C;

    localparam int STATUS_BUSY_BIT     = 0;
    localparam int STATUS_FINISHED_BIT = 1;

endpackage

`default_nettype wire

/* host_apb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "grid_defs.svh"

module host_apb_regs (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          psel_i,
    input  wire                          penable_i,
    input  wire                          pwrite_i,
    input  wire [`APB_ADDR_WIDTH-1:0]    paddr_i,
    input  wire [`APB_DATA_WIDTH-1:0]    pwdata_i,
    output logic [`APB_DATA_WIDTH-1:0]   prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    input  wire                          busy_i,
    input  wire                          finished_i,
    input  wire [`COUNT_WIDTH-1:0]       total_removed_i,
    input  wire [`COUNT_WIDTH-1:0]       passes_i,
    input  wire [`CHUNK_WIDTH-1:0]       host_rdata_i,
    output logic                         host_req_o,
    output logic                         host_we_o,
    output logic [`BANK_ADDR_WIDTH-1:0]  host_addr_o,
    output logic [`CHUNK_WIDTH-1:0]      host_wdata_o,
    output logic                         start_o
);

    host_pkg::reg_sel_t reg_sel;
    logic access, grid_ok, err, grid_rd_go, rd_wait;
    logic [`APB_ADDR_WIDTH-1:0] grid_off;

    always_comb begin
        case (paddr_i)
            host_pkg::OFFSET_CTRL:    reg_sel = host_pkg::REG_CTRL;
            host_pkg::OFFSET_STATUS:  reg_sel = host_pkg::REG_STATUS;
            host_pkg::OFFSET_REMOVED: reg_sel = host_pkg::REG_REMOVED;
            host_pkg::OFFSET_PASSES:  reg_sel = host_pkg::REG_PASSES;
            default: begin
                if (paddr_i >= `GRID_WINDOW_BASE &&
                    paddr_i < `GRID_WINDOW_BASE + 4 * `BANK_DEPTH &&
                    paddr_i[1:0] == 2'b00)
                    reg_sel = host_pkg::REG_GRID;
                else
                    reg_sel = host_pkg::REG_NONE;
            end
        endcase
    end

    assign access  = psel_i && penable_i;
    // the bank belongs to the engine while a job runs
    assign grid_ok = (reg_sel == host_pkg::REG_GRID) && !busy_i;
    assign err     = (reg_sel == host_pkg::REG_NONE) ||
                     (reg_sel == host_pkg::REG_GRID && busy_i);

    // first access cycle of a grid read waits for the bank
    assign grid_rd_go = access && !pwrite_i && grid_ok && !rd_wait;

    always_ff @(posedge clock) begin
        if (reset)
            rd_wait <= 1'b0;
        else
            rd_wait <= grid_rd_go;
    end

    assign grid_off     = paddr_i - `GRID_WINDOW_BASE;
    assign host_addr_o  = grid_off[`BANK_ADDR_WIDTH+1:2];
    assign host_wdata_o = pwdata_i[`CHUNK_WIDTH-1:0];
    assign host_req_o   = access && grid_ok && (pwrite_i || !rd_wait);
    assign host_we_o    = host_req_o && pwrite_i;

    assign pready_o  = !grid_rd_go;
    assign pslverr_o = access && err;
    assign start_o   = access && pwrite_i && (reg_sel == host_pkg::REG_CTRL) &&
                       pwdata_i[0] && !busy_i;

    always_comb begin
        prdata_o = '0;
        case (reg_sel)
            host_pkg::REG_STATUS: begin
                prdata_o[host_pkg::STATUS_BUSY_BIT]     = busy_i;
                prdata_o[host_pkg::STATUS_FINISHED_BIT] = finished_i;
            end
            host_pkg::REG_REMOVED: prdata_o[`COUNT_WIDTH-1:0] = total_removed_i;
            host_pkg::REG_PASSES:  prdata_o[`COUNT_WIDTH-1:0] = passes_i;
            host_pkg::REG_GRID:    prdata_o[`CHUNK_WIDTH-1:0] = host_rdata_i;
            default:               prdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* grid_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "grid_defs.svh"

module grid_bank (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          busy_i,
    input  wire                          host_req_i,
    input  wire                          host_we_i,
    input  wire [`BANK_ADDR_WIDTH-1:0]   host_addr_i,
    input  wire [`CHUNK_WIDTH-1:0]       host_wdata_i,
    output logic [`CHUNK_WIDTH-1:0]      host_rdata_o,
    input  wire                          eng_rd_en_i,
    input  wire                          eng_wr_en_i,
    input  wire [`BANK_ADDR_WIDTH-1:0]   eng_addr_i,
    input  wire [`CHUNK_WIDTH-1:0]       eng_wdata_i,
    output logic [`CHUNK_WIDTH-1:0]      eng_rdata_o,
    output logic                         eng_ack_o
);

    logic [`CHUNK_WIDTH-1:0] mem [`BANK_DEPTH];
    logic [`CHUNK_WIDTH-1:0] rdata_q;

    // busy decides the owner, so there is never a conflict
    always_ff @(posedge clock) begin
        if (busy_i) begin
            if (eng_wr_en_i)
                mem[eng_addr_i] <= eng_wdata_i;
            if (eng_rd_en_i)
                rdata_q <= mem[eng_addr_i];
        end else if (host_req_i) begin
            if (host_we_i)
                mem[host_addr_i] <= host_wdata_i;
            else
                rdata_q <= mem[host_addr_i];
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            eng_ack_o <= 1'b0;
        else
            eng_ack_o <= busy_i && (eng_rd_en_i || eng_wr_en_i);
    end

    assign host_rdata_o = rdata_q;
    assign eng_rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* sweep_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "grid_defs.svh"

module sweep_engine (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          run_i,
    input  wire                          ack_i,
    input  wire [`CHUNK_WIDTH-1:0]       rdata_i,
    output logic                         rd_en_o,
    output logic                         wr_en_o,
    output logic [`BANK_ADDR_WIDTH-1:0]  addr_o,
    output logic [`CHUNK_WIDTH-1:0]      wdata_o,
    output logic                         done_o,
    output logic                         changed_o,
    output logic [`COUNT_WIDTH-1:0]      removed_o
);

    localparam int ROW_W   = $clog2(`GRID_ROWS + 1);
    localparam int CHUNK_W = $clog2(`CHUNKS_PER_ROW + 1);
    localparam int COL_W   = $clog2(`GRID_COLS);

    grid_pkg::engine_state_t state;
    logic pending, prune;
    // ld_row is the row entering the window at the bottom
    logic [ROW_W-1:0] ld_row, row_sel;
    logic [CHUNK_W-1:0] chunk;
    logic [COL_W-1:0] col;
    logic [`GRID_COLS-1:0] row_up, row_cur, row_dn, loaded;
    logic [`GRID_COLS+1:0] up_p, cur_p, dn_p;
    logic [3:0] nb_sum;
    logic [31:0] addr_full;

    // zero padding at both ends, so no wrap-around
    assign up_p  = {1'b0, row_up, 1'b0};
    assign cur_p = {1'b0, row_cur, 1'b0};
    assign dn_p  = {1'b0, row_dn, 1'b0};

    always_comb begin
        nb_sum = up_p[col] + up_p[col+1] + up_p[col+2]
               + cur_p[col] + cur_p[col+2]
               + dn_p[col] + dn_p[col+1] + dn_p[col+2];
        prune = row_cur[col] && (nb_sum < `PRUNE_MIN);
        loaded = row_dn;
        loaded[chunk*`CHUNK_WIDTH +: `CHUNK_WIDTH] = rdata_i;
    end

    assign rd_en_o = (state == grid_pkg::ENG_LOAD) && !pending && (ld_row != `GRID_ROWS);
    assign wr_en_o = (state == grid_pkg::ENG_STORE) && !pending;
    assign done_o  = (state == grid_pkg::ENG_DONE);

    // the row being stored sits one above the row being loaded
    assign row_sel   = (state == grid_pkg::ENG_STORE) ? ld_row - 1'b1 : ld_row;
    assign addr_full = row_sel * `CHUNKS_PER_ROW + chunk;
    assign addr_o    = addr_full[`BANK_ADDR_WIDTH-1:0];
    assign wdata_o   = row_cur[chunk*`CHUNK_WIDTH +: `CHUNK_WIDTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= grid_pkg::ENG_IDLE;
            pending   <= 1'b0;
            ld_row    <= '0;
            chunk     <= '0;
            col       <= '0;
            removed_o <= '0;
            changed_o <= 1'b0;
        end else begin
            case (state)
                grid_pkg::ENG_IDLE, grid_pkg::ENG_DONE: begin
                    if (run_i) begin
                        state     <= grid_pkg::ENG_LOAD;
                        ld_row    <= '0;
                        chunk     <= '0;
                        removed_o <= '0;
                        changed_o <= 1'b0;
                    end
                end
                grid_pkg::ENG_LOAD: begin
                    if (ld_row == `GRID_ROWS) begin
                        // below the last row everything is dead
                        row_dn <= '0;
                        col    <= '0;
                        state  <= grid_pkg::ENG_SWEEP;
                    end else if (rd_en_o) begin
                        pending <= 1'b1;
                    end else if (ack_i) begin
                        pending <= 1'b0;
                        row_dn  <= loaded;
                        if (chunk == `CHUNKS_PER_ROW - 1) begin
                            chunk <= '0;
                            if (ld_row == '0) begin
                                // priming: row 0 becomes current, nothing above it
                                row_up  <= '0;
                                row_cur <= loaded;
                                ld_row  <= ld_row + 1'b1;
                            end else begin
                                col   <= '0;
                                state <= grid_pkg::ENG_SWEEP;
                            end
                        end else begin
                            chunk <= chunk + 1'b1;
                        end
                    end
                end
                grid_pkg::ENG_SWEEP: begin
                    // cleared in place, later columns see it
                    if (prune) begin
                        row_cur[col] <= 1'b0;
                        removed_o    <= removed_o + 1'b1;
                        changed_o    <= 1'b1;
                    end
                    if (col == `GRID_COLS - 1)
                        state <= grid_pkg::ENG_STORE;
                    else
                        col <= col + 1'b1;
                end
                grid_pkg::ENG_STORE: begin
                    if (wr_en_o) begin
                        pending <= 1'b1;
                    end else if (ack_i) begin
                        pending <= 1'b0;
                        if (chunk == `CHUNKS_PER_ROW - 1) begin
                            chunk <= '0;
                            if (ld_row == `GRID_ROWS) begin
                                state <= grid_pkg::ENG_DONE;
                            end else begin
                                row_up  <= row_cur;
                                row_cur <= row_dn;
                                ld_row  <= ld_row + 1'b1;
                                state   <= grid_pkg::ENG_LOAD;
                            end
                        end else begin
                            chunk <= chunk + 1'b1;
                        end
                    end
                end
                default: state <= grid_pkg::ENG_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* pass_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "grid_defs.svh"

module pass_sequencer (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       start_i,
    input  wire                       done_i,
    input  wire                       changed_i,
    input  wire [`COUNT_WIDTH-1:0]    pass_removed_i,
    output logic                      run_o,
    output logic                      busy_o,
    output logic                      finished_o,
    output logic [`COUNT_WIDTH-1:0]   total_removed_o,
    output logic [`COUNT_WIDTH-1:0]   passes_o
);

    grid_pkg::seq_state_t state;

    assign run_o      = (state == grid_pkg::SEQ_RUN);
    assign busy_o     = (state == grid_pkg::SEQ_RUN) || (state == grid_pkg::SEQ_WAIT);
    assign finished_o = (state == grid_pkg::SEQ_FINISHED);

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= grid_pkg::SEQ_IDLE;
            total_removed_o <= '0;
            passes_o        <= '0;
        end else begin
            case (state)
                grid_pkg::SEQ_IDLE, grid_pkg::SEQ_FINISHED: begin
                    if (start_i) begin
                        total_removed_o <= '0;
                        passes_o        <= '0;
                        state           <= grid_pkg::SEQ_RUN;
                    end
                end
                grid_pkg::SEQ_RUN: state <= grid_pkg::SEQ_WAIT;
                grid_pkg::SEQ_WAIT: begin
                    if (done_i) begin
                        total_removed_o <= total_removed_o + pass_removed_i;
                        passes_o        <= passes_o + 1'b1;
                        // a pass without change means the fixed point is reached
                        state <= changed_i ? grid_pkg::SEQ_RUN : grid_pkg::SEQ_FINISHED;
                    end
                end
                default: state <= grid_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* prune_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "grid_defs.svh"

module prune_top (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          psel_i,
    input  wire                          penable_i,
    input  wire                          pwrite_i,
    input  wire [`APB_ADDR_WIDTH-1:0]    paddr_i,
    input  wire [`APB_DATA_WIDTH-1:0]    pwdata_i,
    output logic [`APB_DATA_WIDTH-1:0]   prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o
);

    logic busy, finished, start_pulse, run, done, changed;
    logic host_req, host_we, eng_rd_en, eng_wr_en, eng_ack;
    logic [`BANK_ADDR_WIDTH-1:0] host_addr, eng_addr;
    logic [`CHUNK_WIDTH-1:0] host_wdata, host_rdata, eng_wdata, eng_rdata;
    logic [`COUNT_WIDTH-1:0] total_removed, passes, pass_removed;

    host_apb_regs i_host_apb_regs (
        .clock(clock), .reset(reset),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .busy_i(busy), .finished_i(finished),
        .total_removed_i(total_removed), .passes_i(passes),
        .host_rdata_i(host_rdata), .host_req_o(host_req), .host_we_o(host_we),
        .host_addr_o(host_addr), .host_wdata_o(host_wdata), .start_o(start_pulse)
    );

    grid_bank i_grid_bank (
        .clock(clock), .reset(reset), .busy_i(busy),
        .host_req_i(host_req), .host_we_i(host_we), .host_addr_i(host_addr),
        .host_wdata_i(host_wdata), .host_rdata_o(host_rdata),
        .eng_rd_en_i(eng_rd_en), .eng_wr_en_i(eng_wr_en), .eng_addr_i(eng_addr),
        .eng_wdata_i(eng_wdata), .eng_rdata_o(eng_rdata), .eng_ack_o(eng_ack)
    );

    sweep_engine i_sweep_engine (
        .clock(clock), .reset(reset), .run_i(run),
        .ack_i(eng_ack), .rdata_i(eng_rdata),
        .rd_en_o(eng_rd_en), .wr_en_o(eng_wr_en), .addr_o(eng_addr),
        .wdata_o(eng_wdata), .done_o(done), .changed_o(changed),
        .removed_o(pass_removed)
    );

    pass_sequencer i_pass_sequencer (
        .clock(clock), .reset(reset), .start_i(start_pulse),
        .done_i(done), .changed_i(changed), .pass_removed_i(pass_removed),
        .run_o(run), .busy_o(busy), .finished_o(finished),
        .total_removed_o(total_removed), .passes_o(passes)
    );

endmodule

`default_nettype wire

/* tb_prune_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "grid_defs.svh"

module tb_prune_top;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_ENTRIES = 6;
    localparam int CYCLES_EACH = 2000;
    localparam int NUM_WORDS   = `BANK_DEPTH;

    logic clock;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`APB_DATA_WIDTH-1:0] pwdata;
    wire [`APB_DATA_WIDTH-1:0] prdata;
    wire pready;
    wire pslverr;

    // stimulus rows and expected fixpoint per entry
    logic [`GRID_COLS-1:0] stim_grid [NUM_ENTRIES][`GRID_ROWS];
    logic [`GRID_COLS-1:0] exp_grid [NUM_ENTRIES][`GRID_ROWS];
    bit exp_one_pass [NUM_ENTRIES];
    integer seed;

    prune_top i_dut (
        .clock(clock), .reset(reset),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    initial begin
        #(CLK_PERIOD * (8 + CYCLES_EACH * NUM_ENTRIES));
        $display("timeout: the run hung while waiting for the DUT");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // setup then access; the slave may stretch the access phase with pready
    task automatic apb_xfer(input logic write, input int addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr[`APB_ADDR_WIDTH-1:0];
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        waits = 0;
        @(negedge clock);
        while (!pready) begin
            waits++;
            @(negedge clock);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input int addr, input logic [31:0] data, input logic exp_err,
                             input string what);
        logic [31:0] unused;
        logic err;
        int waits;
        apb_xfer(1'b1, addr, data, unused, err, waits);
        check_equal(err, exp_err, {what, " pslverr"});
        check_equal(waits, 0, {what, " wait states"});
    endtask

    task automatic apb_read(input int addr, output logic [31:0] data, input logic exp_err,
                            input string what);
        logic err;
        int waits;
        int exp_waits;
        // only a grid read that goes through waits for the bank
        exp_waits = (!exp_err && addr >= `GRID_WINDOW_BASE) ? 1 : 0;
        apb_xfer(1'b0, addr, 32'h0, data, err, waits);
        check_equal(err, exp_err, {what, " pslverr"});
        check_equal(waits, exp_waits, {what, " wait states"});
    endtask

    function automatic int grid_addr(input int n);
        return `GRID_WINDOW_BASE + 4 * n;
    endfunction

    function automatic logic [`CHUNK_WIDTH-1:0] word_of(input logic [`GRID_COLS-1:0] row,
                                                        input int c);
        return row[c*`CHUNK_WIDTH +: `CHUNK_WIDTH];
    endfunction

    function automatic int count_live(input logic [`GRID_COLS-1:0] row);
        int k;
        int live;
        live = 0;
        for (k = 0; k < `GRID_COLS; k++)
            live += row[k];
        return live;
    endfunction

    task automatic fill_table();
        logic [31:0] rnd;
        int r;
        for (r = 0; r < `GRID_ROWS; r++) begin
            stim_grid[0][r] = '0;
            stim_grid[1][r] = (r >= 2 && r <= 5) ? 16'h00F0 : 16'h0000;
            stim_grid[2][r] = (r == 3) ? 16'h0FF0 : 16'h0000;
            stim_grid[3][r] = 16'h0001 << r;
            stim_grid[4][r] = 16'hFFFF;
            rnd = $random(seed);
            stim_grid[5][r] = rnd[`GRID_COLS-1:0];
        end
    endtask

    // raster sweeps with clears in place, repeated until a sweep clears nothing
    task automatic build_expected(input int e);
        logic [`GRID_COLS-1:0] g [`GRID_ROWS];
        int r, c, dr, dc, nb, removed_now;
        bit first;
        for (r = 0; r < `GRID_ROWS; r++)
            g[r] = stim_grid[e][r];
        first = 1'b1;
        do begin
            removed_now = 0;
            for (r = 0; r < `GRID_ROWS; r++) begin
                for (c = 0; c < `GRID_COLS; c++) begin
                    if (g[r][c]) begin
                        nb = 0;
                        for (dr = -1; dr <= 1; dr++)
                            for (dc = -1; dc <= 1; dc++)
                                if ((dr != 0 || dc != 0) && r + dr >= 0 && r + dr < `GRID_ROWS
                                    && c + dc >= 0 && c + dc < `GRID_COLS)
                                    nb += g[r+dr][c+dc];
                        if (nb < `PRUNE_MIN) begin
                            g[r][c] = 1'b0;
                            removed_now++;
                        end
                    end
                end
            end
            if (first)
                exp_one_pass[e] = (removed_now == 0);
            first = 1'b0;
        end while (removed_now != 0);
        for (r = 0; r < `GRID_ROWS; r++)
            exp_grid[e][r] = g[r];
    endtask

    initial begin
        int e, n, r, c, live_in, live_out;
        logic [31:0] data;
        clock   = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 91707;
        fill_table();
        for (e = 0; e < NUM_ENTRIES; e++)
            build_expected(e);
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        for (e = 0; e < NUM_ENTRIES; e++) begin
            live_in  = 0;
            live_out = 0;
            for (r = 0; r < `GRID_ROWS; r++) begin
                live_in  += count_live(stim_grid[e][r]);
                live_out += count_live(exp_grid[e][r]);
            end
            for (n = 0; n < NUM_WORDS; n++) begin
                r = n / `CHUNKS_PER_ROW;
                c = n % `CHUNKS_PER_ROW;
                apb_write(grid_addr(n), word_of(stim_grid[e][r], c), 1'b0, "grid load");
            end
            for (n = 0; n < NUM_WORDS; n++) begin
                r = n / `CHUNKS_PER_ROW;
                c = n % `CHUNKS_PER_ROW;
                apb_read(grid_addr(n), data, 1'b0, "grid readback");
                check_equal(data, word_of(stim_grid[e][r], c),
                            $sformatf("entry %0d word %0d before start", e, n));
            end

            apb_write(host_pkg::OFFSET_CTRL, 32'h1, 1'b0, "start");
            apb_read(host_pkg::OFFSET_STATUS, data, 1'b0, "status");
            check_equal(data[host_pkg::STATUS_BUSY_BIT], 1'b1, "busy after start");
            check_equal(data[host_pkg::STATUS_FINISHED_BIT], 1'b0, "finished after start");

            // bank belongs to the engine now, the last word is not yet loaded
            apb_write(grid_addr(NUM_WORDS - 1), 32'hFF, 1'b1, "grid write while busy");
            apb_read(grid_addr(1), data, 1'b1, "grid read while busy");
            apb_write(host_pkg::OFFSET_CTRL, 32'h1, 1'b0, "start while busy");

            do begin
                apb_read(host_pkg::OFFSET_STATUS, data, 1'b0, "status poll");
                check_equal(data[host_pkg::STATUS_BUSY_BIT],
                            !data[host_pkg::STATUS_FINISHED_BIT], "busy against finished");
            end while (!data[host_pkg::STATUS_FINISHED_BIT]);

            apb_write('h10, 32'hFF, 1'b1, "unmapped write");
            apb_read('h84, data, 1'b1, "unmapped read");

            for (n = 0; n < NUM_WORDS; n++) begin
                r = n / `CHUNKS_PER_ROW;
                c = n % `CHUNKS_PER_ROW;
                apb_read(grid_addr(n), data, 1'b0, "final grid");
                check_equal(data, word_of(exp_grid[e][r], c),
                            $sformatf("entry %0d word %0d after job", e, n));
            end

            apb_read(host_pkg::OFFSET_REMOVED, data, 1'b0, "removed");
            check_equal(data, live_in - live_out, $sformatf("entry %0d removed count", e));
            apb_read(host_pkg::OFFSET_PASSES, data, 1'b0, "passes");
            check_equal(data >= 1, 1'b1, $sformatf("entry %0d pass count nonzero", e));
            if (exp_one_pass[e])
                check_equal(data, 32'd1, $sformatf("entry %0d single pass", e));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
grid_pkg.sv
host_pkg.sv
host_apb_regs.sv
grid_bank.sv
sweep_engine.sv
pass_sequencer.sv
prune_top.sv
tb_prune_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_prune_top \
    --Mdir obj_dir -o sim_prune

./obj_dir/sim_prune 2>&1 | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
